// File: common/bch_consts.svh
`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

// BCH(15,5) code, corrects up to three bit errors
`define BCH_N 15			// Codeword length
`define BCH_K 5				// Message length
`define BCH_T 3				// Correctable errors

// Generator x^10+x^8+x^5+x^4+x^2+x+1 without the x^10 term
`define BCH_GEN 10'h137

`define BCH_SLOTS 16			// Message slots in the memory

// Register map, byte addresses
`define BCH_MSG_BASE 8'h00		// 16 message words
`define BCH_CW_BASE 8'h40		// 16 codeword words
`define BCH_CTRL 8'h80			// Start command, slot count in [4:0]
`define BCH_STATUS 8'h84		// {done, busy}

// AXI response codes
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// File: common/bch_pkg.sv
`include "bch_consts.svh"

package bch_pkg;

	typedef logic [`BCH_K-1:0] msg_t;		// Message
	typedef logic [`BCH_N-1:0] cw_t;		// Systematic codeword
	typedef logic [`BCH_N-`BCH_K-1:0] rem_t;	// Parity remainder
	typedef logic [$clog2(`BCH_SLOTS)-1:0] slot_t;

	// Low half messages, high half codewords
	typedef logic [$clog2(`BCH_SLOTS):0] maddr_t;
	typedef logic [15:0] mword_t;

	// One memory access toward the arbiter
	typedef struct packed {
		logic req;
		logic we;
		maddr_t addr;
		mword_t wdata;
	} mem_req_t;

	typedef enum logic [2:0] {
		IDLE,		// Waiting for a start command
		READ,		// Fetching the message word
		ENCODE,		// Feeding bits, collecting the codeword
		WRITE,		// Storing the codeword
		NEXT		// Advancing to the next slot
	} seq_state_e;

endpackage

// File: bch_encode/bch_encode.sv
`timescale 1ns/1ns
`include "bch_consts.svh"

module bch_encode (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic data_in,
	output logic data_out,
	output logic first,
	output logic last,
	output logic busy
);

	bch_pkg::rem_t lfsr;
	logic [3:0] bit_cnt;	// Cycles since start
	logic load;		// Message bits still arriving
	logic fb;

	// Feedback is the incoming bit against the remainder MSB
	assign fb = load & (lfsr[`BCH_N-`BCH_K-1] ^ data_in);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= '0;
			load <= 1'b0;
			busy <= 1'b0;
			first <= 1'b0;
			last <= 1'b0;
		end else begin
			first <= start;	// First output bit follows start
			last <= busy && !start && (bit_cnt == 4'(`BCH_N - 1));

			if (start)
				busy <= 1'b1;
			else if (last)
				busy <= 1'b0;

			if (start)
				bit_cnt <= 4'd1;
			else if (busy)
				bit_cnt <= bit_cnt + 4'd1;

			if (start)
				load <= 1'b1;
			else if (bit_cnt == 4'(`BCH_K - 1))
				load <= 1'b0;	// Last message bit is in this cycle
		end
	end

	// Remainder register and output bit
	always_ff @(posedge clk) begin
		if (start)
			lfsr <= {(`BCH_N-`BCH_K){data_in}} & `BCH_GEN;	// Starts from a clear remainder
		else
			lfsr <= {lfsr[`BCH_N-`BCH_K-2:0], 1'b0} ^ ({(`BCH_N-`BCH_K){fb}} & `BCH_GEN);

		// Message passes through, then the parity shifts out MSB first
		data_out <= (start || load) ? data_in : lfsr[`BCH_N-`BCH_K-1];
	end

endmodule

// File: bch_encode/enc_sequencer.sv
`timescale 1ns/1ns
`include "bch_consts.svh"

module enc_sequencer (
	input logic clk,
	input logic arst_n,
	input logic start_cmd,
	input bch_pkg::slot_t slot_count,	// Last slot index of the batch
	output logic busy,
	output logic done,
	output bch_pkg::mem_req_t mem_req,
	input logic mem_gnt,
	input bch_pkg::mword_t mem_rdata,
	output logic enc_start,
	output logic enc_data,
	input logic enc_out,
	input logic enc_first,
	input logic enc_last
);

	bch_pkg::seq_state_e state;
	bch_pkg::slot_t slot;
	bch_pkg::slot_t last_slot;
	bch_pkg::msg_t msg_sr;		// Message bits, MSB goes out first
	bch_pkg::cw_t cw_sr;		// Codeword being assembled
	logic [2:0] feed_left;		// Message bits still to send
	logic load_msg;			// Read data arrives this cycle
	logic collect;			// Between first and last output bits
	logic feeding;

	assign feeding = (state == bch_pkg::ENCODE) && (feed_left != 3'd0);
	assign enc_start = feeding && (feed_left == 3'(`BCH_K));
	assign enc_data = feeding && msg_sr[`BCH_K-1];

	always_comb begin
		mem_req.req = (state == bch_pkg::READ) || (state == bch_pkg::WRITE);
		mem_req.we = (state == bch_pkg::WRITE);
		mem_req.addr = {state == bch_pkg::WRITE, slot};	// Codeword half on write
		mem_req.wdata = {1'b0, cw_sr};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= bch_pkg::IDLE;
			slot <= '0;
			last_slot <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			feed_left <= 3'd0;
			load_msg <= 1'b0;
			collect <= 1'b0;
		end else begin
			case (state)
				bch_pkg::IDLE: begin
					if (start_cmd) begin
						slot <= '0;
						last_slot <= slot_count;
						busy <= 1'b1;
						done <= 1'b0;	// Cleared by the next batch
						state <= bch_pkg::READ;
					end
				end
				bch_pkg::READ: begin
					if (mem_gnt) begin
						load_msg <= 1'b1;
						state <= bch_pkg::ENCODE;
					end
				end
				bch_pkg::ENCODE: begin
					load_msg <= 1'b0;
					if (load_msg)
						feed_left <= 3'(`BCH_K);
					else if (feed_left != 3'd0)
						feed_left <= feed_left - 3'd1;

					if (enc_first)
						collect <= 1'b1;
					else if (enc_last)
						collect <= 1'b0;

					if (enc_last)
						state <= bch_pkg::WRITE;	// Last bit shifts in on this edge
				end
				bch_pkg::WRITE: begin
					if (mem_gnt)
						state <= bch_pkg::NEXT;
				end
				bch_pkg::NEXT: begin
					if (slot == last_slot) begin
						busy <= 1'b0;
						done <= 1'b1;
						state <= bch_pkg::IDLE;
					end else begin
						slot <= slot + 1'b1;
						state <= bch_pkg::READ;
					end
				end
				default: state <= bch_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == bch_pkg::ENCODE) && load_msg)
			msg_sr <= mem_rdata[`BCH_K-1:0];
		else if (feeding)
			msg_sr <= msg_sr << 1;

		if (enc_first || collect)
			cw_sr <= {cw_sr[`BCH_N-2:0], enc_out};	// Bit 14 arrives first
	end

endmodule

// File: verilog/axil_regs.sv
`timescale 1ns/1ns
`include "bch_consts.svh"

module axil_regs (
	input logic clk,
	input logic arst_n,
	input logic [7:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,		// Full-word writes only
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [7:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output bch_pkg::mem_req_t mem_req,
	input logic mem_gnt,
	input bch_pkg::mword_t mem_rdata,
	output logic start_cmd,
	output bch_pkg::slot_t slot_count,
	input logic seq_busy,
	input logic seq_done
);

	typedef enum logic [2:0] {
		AX_IDLE,
		AX_WDEC,	// Write handshake and decode
		AX_WMEM,	// Message write waiting for grant
		AX_BRESP,
		AX_RDEC,	// Read handshake and decode
		AX_RMEM,	// Region read waiting for grant
		AX_RDATA,	// Memory data arrives
		AX_RRESP
	} ax_state_e;

	ax_state_e state;
	logic [7:0] addr_q;
	bch_pkg::mword_t data_q;
	logic [4:0] ctrl_count;		// Requested number of slots
	logic in_msg;
	logic in_cw;
	logic is_ctrl;
	logic is_status;
	logic ctrl_go;

	// Each region spans 16 words, selected by address bits 7:6
	assign in_msg = (addr_q[7:6] == 2'(`BCH_MSG_BASE >> 6));
	assign in_cw = (addr_q[7:6] == 2'(`BCH_CW_BASE >> 6));
	assign is_ctrl = (addr_q == `BCH_CTRL);
	assign is_status = (addr_q == `BCH_STATUS);
	assign ctrl_count = data_q[4:0];
	assign ctrl_go = (state == AX_WDEC) && is_ctrl && !seq_busy &&
		(ctrl_count != 5'd0) && (ctrl_count <= 5'(`BCH_SLOTS));

	always_comb begin
		mem_req.req = (state == AX_WMEM) || (state == AX_RMEM);
		mem_req.we = (state == AX_WMEM);
		mem_req.addr = {in_cw, addr_q[5:2]};
		mem_req.wdata = {{($bits(bch_pkg::mword_t)-`BCH_K){1'b0}}, data_q[`BCH_K-1:0]};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= AX_IDLE;
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= `AXI_RESP_OKAY;
			rvalid <= 1'b0;
			rresp <= `AXI_RESP_OKAY;
			start_cmd <= 1'b0;
		end else begin
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			start_cmd <= ctrl_go;	// One-cycle pulse
			case (state)
				AX_IDLE: begin
					if (awvalid && wvalid) begin	// Writes win over reads
						awready <= 1'b1;
						wready <= 1'b1;
						state <= AX_WDEC;
					end else if (arvalid) begin
						arready <= 1'b1;
						state <= AX_RDEC;
					end
				end
				AX_WDEC: begin
					if (in_msg) begin
						bresp <= `AXI_RESP_OKAY;
						state <= AX_WMEM;
					end else begin
						// Codeword, STATUS, unmapped or refused CTRL
						bresp <= ctrl_go ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
						bvalid <= 1'b1;
						state <= AX_BRESP;
					end
				end
				AX_WMEM: begin
					if (mem_gnt) begin
						bvalid <= 1'b1;
						state <= AX_BRESP;
					end
				end
				AX_BRESP: begin
					if (bready) begin
						bvalid <= 1'b0;
						state <= AX_IDLE;
					end
				end
				AX_RDEC: begin
					if (in_msg || in_cw) begin
						state <= AX_RMEM;
					end else begin
						rresp <= (is_status || is_ctrl) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
						rvalid <= 1'b1;
						state <= AX_RRESP;
					end
				end
				AX_RMEM: begin
					if (mem_gnt)
						state <= AX_RDATA;
				end
				AX_RDATA: begin
					rresp <= `AXI_RESP_OKAY;
					rvalid <= 1'b1;
					state <= AX_RRESP;
				end
				AX_RRESP: begin
					if (rready) begin
						rvalid <= 1'b0;
						state <= AX_IDLE;
					end
				end
				default: state <= AX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == AX_IDLE) begin
			if (awvalid && wvalid) begin
				addr_q <= awaddr;
				data_q <= wdata[15:0];
			end else if (arvalid) begin
				addr_q <= araddr;
			end
		end

		// CTRL is write-only and reads as zero
		if (state == AX_RDEC)
			rdata <= is_status ? {30'd0, seq_done, seq_busy} : 32'd0;
		else if (state == AX_RDATA)
			rdata <= {16'd0, mem_rdata};

		if (ctrl_go)
			slot_count <= bch_pkg::slot_t'(ctrl_count - 5'd1);	// Sequencer takes last index
	end

endmodule

// File: verilog/slot_memory.sv
`timescale 1ns/1ns
`include "bch_consts.svh"

module slot_memory (
	input logic clk,
	input logic arst_n,
	input bch_pkg::mem_req_t host_req,
	output logic host_gnt,
	output bch_pkg::mword_t host_rdata,
	input bch_pkg::mem_req_t seq_req,
	output logic seq_gnt,
	output bch_pkg::mword_t seq_rdata
);

	bch_pkg::mword_t mem [0:2*`BCH_SLOTS-1];	// Messages, then codewords
	bch_pkg::mem_req_t gnt_req;
	logic last_seq;				// Sequencer was served last

	// On a tie the side not served last wins
	assign host_gnt = host_req.req && (!seq_req.req || last_seq);
	assign seq_gnt = seq_req.req && (!host_req.req || !last_seq);
	assign gnt_req = seq_gnt ? seq_req : host_req;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			last_seq <= 1'b0;
		else if (host_gnt)
			last_seq <= 1'b0;
		else if (seq_gnt)
			last_seq <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if ((host_gnt || seq_gnt) && gnt_req.we)
			mem[gnt_req.addr] <= gnt_req.wdata;

		// Read data is valid the cycle after the grant
		if (host_gnt && !host_req.we)
			host_rdata <= mem[host_req.addr];
		if (seq_gnt && !seq_req.we)
			seq_rdata <= mem[seq_req.addr];
	end

endmodule

// File: verilog/bch_enc_top.sv
`timescale 1ns/1ns

module bch_enc_top (
	input logic clk,
	input logic arst_n,
	input logic [7:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [7:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	bch_pkg::mem_req_t host_req;
	bch_pkg::mem_req_t seq_req;
	bch_pkg::mword_t host_rdata;
	bch_pkg::mword_t seq_rdata;
	bch_pkg::slot_t slot_count;
	logic host_gnt;
	logic seq_gnt;
	logic start_cmd;
	logic seq_busy;
	logic seq_done;
	logic enc_start;
	logic enc_data;
	logic enc_out;
	logic enc_first;
	logic enc_last;

	axil_regs i_axil_regs (
		.clk(clk),
		.arst_n(arst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.mem_req(host_req),
		.mem_gnt(host_gnt),
		.mem_rdata(host_rdata),
		.start_cmd(start_cmd),
		.slot_count(slot_count),
		.seq_busy(seq_busy),
		.seq_done(seq_done)
	);

	enc_sequencer i_enc_sequencer (
		.clk(clk),
		.arst_n(arst_n),
		.start_cmd(start_cmd),
		.slot_count(slot_count),
		.busy(seq_busy),
		.done(seq_done),
		.mem_req(seq_req),
		.mem_gnt(seq_gnt),
		.mem_rdata(seq_rdata),
		.enc_start(enc_start),
		.enc_data(enc_data),
		.enc_out(enc_out),
		.enc_first(enc_first),
		.enc_last(enc_last)
	);

	// Encoder busy is only watched by the checker
	bch_encode i_bch_encode (
		.clk(clk),
		.arst_n(arst_n),
		.start(enc_start),
		.data_in(enc_data),
		.data_out(enc_out),
		.first(enc_first),
		.last(enc_last),
		.busy()
	);

	slot_memory i_slot_memory (
		.clk(clk),
		.arst_n(arst_n),
		.host_req(host_req),
		.host_gnt(host_gnt),
		.host_rdata(host_rdata),
		.seq_req(seq_req),
		.seq_gnt(seq_gnt),
		.seq_rdata(seq_rdata)
	);

endmodule

// File: verification/bch_enc_checker.sv
`timescale 1ns/1ns

module bch_enc_checker (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic first,
	input logic last,
	input logic busy,
	input logic host_req,
	input logic host_gnt,
	input logic seq_req,
	input logic seq_gnt
);

	int fail_count = 0;

	// Codeword framing spans 15 cycles after start
	first_after_start: assert property (@(posedge clk) disable iff (!arst_n)
		start |=> first ##14 last)
		else begin
			fail_count++;
			$error("first or last out of place after start");
		end

	last_in_busy: assert property (@(posedge clk) disable iff (!arst_n)
		last |-> busy)
		else begin
			fail_count++;
			$error("last high without busy");
		end

	one_grant: assert property (@(posedge clk) disable iff (!arst_n)
		!(host_gnt && seq_gnt))
		else begin
			fail_count++;
			$error("both memory grants high");
		end

	// A losing requester wins the next cycle
	host_served: assert property (@(posedge clk) disable iff (!arst_n)
		(host_req && !host_gnt) |=> host_gnt)
		else begin
			fail_count++;
			$error("host request not granted within two cycles");
		end

	seq_served: assert property (@(posedge clk) disable iff (!arst_n)
		(seq_req && !seq_gnt) |=> seq_gnt)
		else begin
			fail_count++;
			$error("sequencer request not granted within two cycles");
		end

endmodule

bind bch_encode bch_enc_checker i_bch_enc_checker (
	.clk(clk),
	.arst_n(arst_n),
	.start(start),
	.first(first),
	.last(last),
	.busy(busy),
	.host_req(1'b0),
	.host_gnt(1'b0),
	.seq_req(1'b0),
	.seq_gnt(1'b0)
);

bind slot_memory bch_enc_checker i_bch_enc_checker (
	.clk(clk),
	.arst_n(arst_n),
	.start(1'b0),
	.first(1'b0),
	.last(1'b0),
	.busy(1'b0),
	.host_req(host_req.req),
	.host_gnt(host_gnt),
	.seq_req(seq_req.req),
	.seq_gnt(seq_gnt)
);

// File: verification/bch_monitor.sv
`timescale 1ns/1ns

module bch_monitor (
	input logic clk,
	input logic arst_n,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic exp_push,
	input logic exp_read,
	input logic [31:0] exp_data,
	input logic [31:0] exp_mask,
	input logic [1:0] exp_resp,
	output int error_count,
	output int pending
);

	typedef struct packed {
		logic is_read;
		logic [31:0] data;
		logic [31:0] mask;		// Bits of rdata that are compared
		logic [1:0] resp;
	} expect_t;

	expect_t exp_q [$];
	expect_t cur;
	int errors = 0;
	int outstanding = 0;

	assign error_count = errors;
	assign pending = outstanding;

	always @(posedge clk) begin
		if (arst_n) begin
			if ((bvalid || rvalid) && exp_q.size() == 0) begin
				errors++;
				$display("Response valid at %0t with no transaction outstanding", $time);
			end else if (bvalid && bready) begin
				cur = exp_q.pop_front();
				if (cur.is_read) begin
					errors++;
					$display("Write response at %0t while a read response was due", $time);
				end else if (bresp !== cur.resp) begin
					errors++;
					$display("FAILED time %0t: bresp expected %h got %h", $time, cur.resp, bresp);
				end
			end else if (rvalid && rready) begin
				cur = exp_q.pop_front();
				if (!cur.is_read) begin
					errors++;
					$display("Read response at %0t while a write response was due", $time);
				end else begin
					if (rresp !== cur.resp) begin
						errors++;
						$display("FAILED time %0t: rresp expected %h got %h",
							$time, cur.resp, rresp);
					end
					if ((rdata & cur.mask) !== (cur.data & cur.mask)) begin
						errors++;
						$display("FAILED time %0t: rdata expected %h got %h",
							$time, cur.data & cur.mask, rdata & cur.mask);
					end
				end
			end
		end
		if (exp_push)
			exp_q.push_back({exp_read, exp_data, exp_mask, exp_resp});
		outstanding = exp_q.size();
	end

endmodule

// File: verification/tb_bch_enc.sv
`timescale 1ns/1ns
`include "bch_consts.svh"

module tb_bch_enc;

	localparam int NUM_VEC = `BCH_SLOTS;
	localparam int TIMEOUT_CYCLES = 200 * NUM_VEC + 2000;

	logic clk;
	logic arst_n;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic exp_push;				// One cycle per posted transaction
	logic exp_read;
	logic [31:0] exp_data;
	logic [31:0] exp_mask;
	logic [1:0] exp_resp;
	int mon_errors;
	int mon_pending;

	logic [15:0] vectors [0:2*NUM_VEC-1];	// Message, codeword pairs
	logic [31:0] rand_state = 32'h8de6;
	int cycles = 0;

	bch_enc_top i_bch_enc_top (.*);

	bch_monitor i_bch_monitor (
		.error_count(mon_errors),
		.pending(mon_pending),
		.*
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	task automatic post_expect(input logic is_read, input logic [31:0] data,
		input logic [31:0] mask, input logic [1:0] resp);
		exp_push <= 1'b1;
		exp_read <= is_read;
		exp_data <= data;
		exp_mask <= mask;
		exp_resp <= resp;
	endtask

	task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
		input logic [1:0] resp);
		int stall;
		stall = int'(next_random() >> 30);	// bready held off 0 to 3 cycles
		post_expect(1'b0, 32'd0, 32'd0, resp);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		@(posedge clk);
		exp_push <= 1'b0;
		while (!(awready && wready))
			@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		while (!bvalid)
			@(posedge clk);
		repeat (stall)
			@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic read_word(input logic [7:0] addr, input logic [31:0] data,
		input logic [31:0] mask, input logic [1:0] resp, output logic [31:0] got);
		int stall;
		stall = int'(next_random() >> 30);
		post_expect(1'b1, data, mask, resp);
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		exp_push <= 1'b0;
		while (!arready)
			@(posedge clk);
		arvalid <= 1'b0;
		while (!rvalid)
			@(posedge clk);
		repeat (stall)
			@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		got = rdata;	// Handshake edge
		rready <= 1'b0;
	endtask

	task automatic check_codewords();
		logic [31:0] rd;
		for (int i = 0; i < NUM_VEC; i++)
			read_word(`BCH_CW_BASE + 8'(4 * i), {16'd0, vectors[2*i+1]}, 32'hffff_ffff,
				`AXI_RESP_OKAY, rd);
	endtask

	task automatic check_messages();
		logic [31:0] rd;
		for (int i = 0; i < NUM_VEC; i++)
			read_word(`BCH_MSG_BASE + 8'(4 * i), {27'd0, vectors[2*i][4:0]}, 32'hffff_ffff,
				`AXI_RESP_OKAY, rd);
	endtask

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] status;
		int asrt_errors;
		arst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		exp_push = 1'b0;
		exp_read = 1'b0;
		exp_data = '0;
		exp_mask = '0;
		exp_resp = '0;
		$readmemh("verification/bch_vectors.mem", vectors);
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		read_word(`BCH_STATUS, 32'd0, 32'hffff_ffff, `AXI_RESP_OKAY, rd);

		for (int i = 0; i < NUM_VEC; i++)
			write_word(`BCH_MSG_BASE + 8'(4 * i), {27'd0, vectors[2*i][4:0]}, `AXI_RESP_OKAY);
		check_messages();

		// Full batch, a restart attempt is refused while it runs
		write_word(`BCH_CTRL, 32'(NUM_VEC), `AXI_RESP_OKAY);
		read_word(`BCH_STATUS, 32'd1, 32'hffff_ffff, `AXI_RESP_OKAY, rd);
		write_word(`BCH_CTRL, 32'(NUM_VEC), `AXI_RESP_SLVERR);
		check_messages();	// Competes with the sequencer

		status = 32'd1;
		while (status[1:0] != 2'b10)
			read_word(`BCH_STATUS, 32'd0, 32'hffff_fffc, `AXI_RESP_OKAY, status);
		read_word(`BCH_STATUS, 32'd2, 32'hffff_ffff, `AXI_RESP_OKAY, rd);
		check_codewords();

		for (int i = 0; i < NUM_VEC; i += 5)
			write_word(`BCH_CW_BASE + 8'(4 * i), 32'h1234, `AXI_RESP_SLVERR);
		write_word(`BCH_STATUS, 32'd0, `AXI_RESP_SLVERR);
		write_word(8'hc0, 32'd1, `AXI_RESP_SLVERR);
		read_word(8'hc4, 32'd0, 32'hffff_ffff, `AXI_RESP_SLVERR, rd);
		check_codewords();	// Untouched by the refused writes

		repeat (4) @(posedge clk);
		asrt_errors = i_bch_enc_top.i_bch_encode.i_bch_enc_checker.fail_count +
			i_bch_enc_top.i_slot_memory.i_bch_enc_checker.fail_count;
		$display("Errors: %0d compare, %0d assertion, %0d responses missing",
			mon_errors, asrt_errors, mon_pending);
		if (mon_errors == 0 && asrt_errors == 0 && mon_pending == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: verification/bch_vectors.mem
// Columns: message (5 bits), expected codeword (15 bits), both hex
// Codeword is the message times x^10 with its remainder modulo the generator appended
00 0000
01 0537
02 0a6e
04 11eb
08 23d6
10 429b
1f 7fff
15 5647
0a 29b8
13 4dc2
0c 323d
07 1eb2
19 647a
1e 7ac8
11 47ac
0d 370a

// File: tb.f
+incdir+common
common/bch_pkg.sv
bch_encode/bch_encode.sv
bch_encode/enc_sequencer.sv
verilog/axil_regs.sv
verilog/slot_memory.sv
verilog/bch_enc_top.sv
verification/bch_enc_checker.sv
verification/bch_monitor.sv
verification/tb_bch_enc.sv
